/* common/qspim_pkg.sv */
// Register map, sequence codes and bus/FIFO word layouts
// Word addressed register bus, 4-bit address and 32-bit data only
// Command FIFO layout must match the SPI engine on the far side

package qspim_pkg;

  // ------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------
  localparam int WB_AW       = 4;
  localparam int WB_DW       = 32;
  localparam int CMD_FIFO_WD = 36;   // SOC + EOC + 34-bit payload

  // Register word addresses
  localparam logic [WB_AW-1:0] GLBL_CTRL     = 4'h0;
  localparam logic [WB_AW-1:0] DMEM_CTRL1    = 4'h1;
  localparam logic [WB_AW-1:0] DMEM_CTRL2    = 4'h2;
  localparam logic [WB_AW-1:0] DMEM_CS_AMAP  = 4'h3;  // Per CS address byte
  localparam logic [WB_AW-1:0] DMEM_CS_AMASK = 4'h4;  // Per CS mask byte
  localparam logic [WB_AW-1:0] IMEM_CTRL1    = 4'h5;
  localparam logic [WB_AW-1:0] IMEM_CTRL2    = 4'h6;
  localparam logic [WB_AW-1:0] IMEM_ADDR     = 4'h7;
  localparam logic [WB_AW-1:0] IMEM_WDATA    = 4'h8;  // Write pushes to cmd FIFO
  localparam logic [WB_AW-1:0] IMEM_RDATA    = 4'h9;  // Read pops the res FIFO

  // ------------------------------------------------------------------
  // SPI sequence codes
  // ------------------------------------------------------------------
  localparam logic [3:0] P_FSM_C     = 4'b0000;  // Cmd only
  localparam logic [3:0] P_FSM_CW    = 4'b0001;  // Cmd, write
  localparam logic [3:0] P_FSM_CA    = 4'b0010;  // Cmd, addr
  localparam logic [3:0] P_FSM_CAR   = 4'b0011;  // Cmd, addr, read
  localparam logic [3:0] P_FSM_CADR  = 4'b0100;  // Cmd, addr, dummy, read
  localparam logic [3:0] P_FSM_CAMR  = 4'b0101;  // Cmd, addr, mode, read
  localparam logic [3:0] P_FSM_CAMDR = 4'b0110;  // Cmd, addr, mode, dummy, read
  localparam logic [3:0] P_FSM_CAW   = 4'b0111;  // Cmd, addr, write
  localparam logic [3:0] P_FSM_CADW  = 4'b1000;  // Cmd, addr, dummy, write
  localparam logic [3:0] P_FSM_CAMW  = 4'b1001;  // Cmd, addr, mode, write
  localparam logic [3:0] P_FSM_CDR   = 4'b1010;  // Cmd, dummy, read
  localparam logic [3:0] P_FSM_CDW   = 4'b1011;  // Cmd, dummy, write
  localparam logic [3:0] P_FSM_CR    = 4'b1100;  // Cmd, read

  // Lane modes
  localparam logic [1:0] P_SINGLE = 2'b00;
  localparam logic [1:0] P_DOUBLE = 2'b01;
  localparam logic [1:0] P_QUAD   = 2'b10;
  localparam logic [1:0] P_QDDR   = 2'b11;

  // Where imode hands over to fmode
  localparam logic [1:0] P_MODE_SWITCH_IDLE    = 2'b00;
  localparam logic [1:0] P_MODE_SWITCH_AT_ADDR = 2'b01;
  localparam logic [1:0] P_MODE_SWITCH_AT_DATA = 2'b10;

  localparam logic [7:0] P_QIOR = 8'hEB;  // Quad IO read, direct default
  localparam logic [7:0] P_QOR  = 8'h6B;  // Quad out read, indirect default
  localparam logic [3:0] P_CS0  = 4'b0001;

  // ------------------------------------------------------------------
  // Packed structs
  // ------------------------------------------------------------------
  typedef struct packed {
    logic [1:0] imode;      // Lanes before switch point
    logic [1:0] fmode;      // Lanes after switch point
    logic [1:0] switch;
    logic [3:0] dummy_cnt;
    logic       fsm_reset;
    logic [7:0] cmd;
    logic [7:0] mode;
    logic [3:0] seq;
    logic [1:0] addr_cnt;
    logic [7:0] data_cnt;   // Bytes
  } spi_mode_cfg_t;

  typedef struct packed {
    logic [3:0][7:0] addr;   // Index = chip select
    logic [3:0][7:0] amask;
  } cs_map_t;

  typedef struct packed {
    logic [1:0] cs_early;
    logic [1:0] cs_late;
    logic [7:0] clk_div;
  } glbl_cfg_t;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [3:0]       sel;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  // Header word payload, 34 bits
  typedef struct packed {
    logic [7:0] data_cnt;
    logic [3:0] dummy_cnt;
    logic [1:0] addr_cnt;
    logic [3:0] seq;
    logic [7:0] mode;
    logic [7:0] cmd;
  } cmd_hdr_t;

  // Payload is a header, or 2'b00 and an address/data word
  typedef struct packed {
    logic                   soc;
    logic                   eoc;
    logic [CMD_FIFO_WD-3:0] payload;
  } cmd_word_t;

endpackage

/* design/qspim_wb_slave.sv */
// Wishbone classic decode, master holds request until ack
// Plain registers ack after one cycle, indirect ones wait for the engine

`timescale 1ns/1ps

module qspim_wb_slave import qspim_pkg::*; (
  input  logic             mclk,
  input  logic             rst_n,
  input  wb_req_t          wb_req,
  output logic             wb_ack,
  output logic [WB_DW-1:0] wb_rdata,
  output logic             reg_we,
  input  logic [WB_DW-1:0] reg_rdata,
  output logic             imem_wr_req,
  output logic             imem_rd_req,
  input  logic             wrdy,
  input  logic             rrdy,
  input  logic [WB_DW-1:0] imem_rdata
);

  logic req_vld;     // Live request, not yet acked
  logic hit_wdata;
  logic hit_rdata;
  logic reg_rd;      // Plain register read
  logic ack_nxt;

  // ------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------
  assign req_vld   = wb_req.cyc & wb_req.stb & ~wb_ack;  // Mask ack cycle
  assign hit_wdata = (wb_req.adr == IMEM_WDATA);
  assign hit_rdata = (wb_req.adr == IMEM_RDATA);

  assign imem_wr_req = req_vld &  wb_req.we &  hit_wdata;
  assign imem_rd_req = req_vld & ~wb_req.we &  hit_rdata;
  assign reg_we      = req_vld &  wb_req.we & ~hit_wdata;
  assign reg_rd      = req_vld & ~wb_req.we & ~hit_rdata;

  // Indirect accesses finish on the engine's qualifier
  assign ack_nxt = reg_we | reg_rd
                 | (imem_wr_req & wrdy)
                 | (imem_rd_req & rrdy);

  // ------------------------------------------------------------------
  // Ack and read data
  // ------------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= ack_nxt;   // One cycle pulse, req_vld drops with it
    end
  end

  always_ff @(posedge mclk) begin
    if (reg_rd) begin
      wb_rdata <= reg_rdata;
    end else if (imem_rd_req && rrdy) begin
      wb_rdata <= imem_rdata;   // Word popped this cycle
    end
  end

endmodule

/* design/qspim_cfg_regs.sv */
// Configuration registers with byte lane writes under sel
// Readback follows the write field packing
// IMEM_RDATA is served by the indirect engine and reads zero here

`timescale 1ns/1ps

module qspim_cfg_regs import qspim_pkg::*; (
  input  logic             mclk,
  input  logic             rst_n,
  input  wb_req_t          wb_req,
  input  logic             reg_we,
  output logic [WB_DW-1:0] reg_rdata,
  output glbl_cfg_t        glbl_cfg,
  output spi_mode_cfg_t    dmem_cfg,
  output cs_map_t          dmem_cs_map,
  output logic [3:0]       imem_cs,
  output spi_mode_cfg_t    imem_cfg,
  output logic [31:0]      imem_addr,
  input  logic [31:0]      imem_wdata_last
);

  logic [3:0]       sel;
  logic [WB_DW-1:0] wdat;

  assign sel  = wb_req.sel;
  assign wdat = wb_req.dat;

  // ------------------------------------------------------------------
  // Field helpers, shared by direct and indirect setups
  // ------------------------------------------------------------------
  function automatic spi_mode_cfg_t wr_ctrl1(spi_mode_cfg_t cur, logic [3:0] be,
                                             logic [31:0] d);
    spi_mode_cfg_t nxt;
    nxt = cur;
    if (be[0]) begin
      nxt.imode = d[5:4];
      nxt.fmode = d[7:6];
    end
    if (be[1]) begin
      nxt.switch    = d[9:8];
      nxt.dummy_cnt = d[13:10];
      nxt.fsm_reset = d[15];   // Bit 14 reserved
    end
    return nxt;
  endfunction

  function automatic spi_mode_cfg_t wr_ctrl2(spi_mode_cfg_t cur, logic [3:0] be,
                                             logic [31:0] d);
    spi_mode_cfg_t nxt;
    nxt = cur;
    if (be[0]) nxt.cmd = d[7:0];
    if (be[1]) nxt.mode = d[15:8];
    if (be[2]) begin
      nxt.seq      = d[19:16];
      nxt.addr_cnt = d[21:20];
    end
    if (be[3]) nxt.data_cnt = d[31:24];
    return nxt;
  endfunction

  // Plain byte merge for whole-word registers
  function automatic logic [31:0] wr_bytes(logic [31:0] cur, logic [3:0] be,
                                           logic [31:0] d);
    logic [31:0] nxt;
    nxt = cur;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) nxt[8*i +: 8] = d[8*i +: 8];
    end
    return nxt;
  endfunction

  function automatic logic [31:0] rd_ctrl1(spi_mode_cfg_t c);
    return {16'h0, c.fsm_reset, 1'b0, c.dummy_cnt, c.switch, c.fmode, c.imode, 4'h0};
  endfunction

  function automatic logic [31:0] rd_ctrl2(spi_mode_cfg_t c);
    return {c.data_cnt, 2'b00, c.addr_cnt, c.seq, c.mode, c.cmd};
  endfunction

  // ------------------------------------------------------------------
  // Register writes
  // ------------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      glbl_cfg <= '{cs_early: 2'd1, cs_late: 2'd1, clk_div: 8'd2};
      // Direct reads default to quad IO with mode and dummy, 32 bytes
      dmem_cfg <= '{imode: P_QUAD, fmode: P_QUAD, switch: P_MODE_SWITCH_AT_ADDR,
                    dummy_cnt: 4'd1, fsm_reset: 1'b0, cmd: P_QIOR, mode: 8'h00,
                    seq: P_FSM_CAMDR, addr_cnt: 2'd2, data_cnt: 8'h20};
      imem_cfg <= '{imode: P_QUAD, fmode: P_QUAD, switch: P_MODE_SWITCH_AT_DATA,
                    dummy_cnt: 4'd0, fsm_reset: 1'b0, cmd: P_QOR, mode: 8'h00,
                    seq: P_FSM_CADR, addr_cnt: 2'd2, data_cnt: 8'h00};
      // 16MB window per chip select
      dmem_cs_map.addr  <= {8'h30, 8'h20, 8'h10, 8'h00};
      dmem_cs_map.amask <= {4{8'hF0}};
      imem_cs   <= P_CS0;
      imem_addr <= '0;
    end else if (reg_we) begin
      case (wb_req.adr)
        GLBL_CTRL: begin
          if (sel[0]) begin
            glbl_cfg.cs_early <= wdat[1:0];
            glbl_cfg.cs_late  <= wdat[3:2];
          end
          if (sel[1]) glbl_cfg.clk_div <= wdat[15:8];
        end
        DMEM_CTRL1:    dmem_cfg <= wr_ctrl1(dmem_cfg, sel, wdat);
        DMEM_CTRL2:    dmem_cfg <= wr_ctrl2(dmem_cfg, sel, wdat);
        DMEM_CS_AMAP:  dmem_cs_map.addr  <= wr_bytes(dmem_cs_map.addr, sel, wdat);
        DMEM_CS_AMASK: dmem_cs_map.amask <= wr_bytes(dmem_cs_map.amask, sel, wdat);
        IMEM_CTRL1: begin
          imem_cfg <= wr_ctrl1(imem_cfg, sel, wdat);
          if (sel[0]) imem_cs <= wdat[3:0];   // One-hot CS
        end
        IMEM_CTRL2:    imem_cfg  <= wr_ctrl2(imem_cfg, sel, wdat);
        IMEM_ADDR:     imem_addr <= wr_bytes(imem_addr, sel, wdat);
        default: ;   // IMEM_WDATA goes to the engine
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------------
  always_comb begin
    reg_rdata = '0;
    case (wb_req.adr)
      GLBL_CTRL:     reg_rdata = {16'h0, glbl_cfg.clk_div, 4'h0,
                                  glbl_cfg.cs_late, glbl_cfg.cs_early};
      DMEM_CTRL1:    reg_rdata = rd_ctrl1(dmem_cfg);
      DMEM_CTRL2:    reg_rdata = rd_ctrl2(dmem_cfg);
      DMEM_CS_AMAP:  reg_rdata = dmem_cs_map.addr;
      DMEM_CS_AMASK: reg_rdata = dmem_cs_map.amask;
      IMEM_CTRL1:    reg_rdata = rd_ctrl1(imem_cfg) | {28'h0, imem_cs};
      IMEM_CTRL2:    reg_rdata = rd_ctrl2(imem_cfg);
      IMEM_ADDR:     reg_rdata = imem_addr;
      IMEM_WDATA:    reg_rdata = imem_wdata_last;   // Last word pushed
      default:       reg_rdata = '0;
    endcase
  end

endmodule

/* design/qspim_imem_ctrl.sv */
// Indirect access engine, one transaction at a time
// Launches only on an empty command FIFO, fsm_reset holds it idle
// Data count is in bytes, words per phase = (data_cnt - 1) / 4 + 1

`timescale 1ns/1ps

module qspim_imem_ctrl import qspim_pkg::*; (
  input  logic             mclk,
  input  logic             rst_n,
  input  spi_mode_cfg_t    imem_cfg,
  input  logic [31:0]      imem_addr,
  input  logic             wr_req,
  input  logic [WB_DW-1:0] wr_data,
  input  logic             rd_req,
  output logic             wrdy,
  output logic             rrdy,
  output logic [WB_DW-1:0] rdata,
  output logic [WB_DW-1:0] wdata_last,
  input  logic             cmd_fifo_full,
  input  logic             cmd_fifo_empty,
  output logic             cmd_fifo_wr,
  output cmd_word_t        cmd_fifo_wdata,
  input  logic             res_fifo_empty,
  input  logic [WB_DW-1:0] res_fifo_rdata,
  output logic             res_fifo_rd
);

  typedef enum logic [2:0] {
    S_IDLE, S_ADDR, S_WRITE, S_WR_BUSY, S_READ, S_RD_BUSY, S_ACK
  } state_t;

  state_t     state;
  state_t     next_state;
  logic [5:0] cnt;           // Data word index
  logic [5:0] next_cnt;
  logic [7:0] cnt_m1;
  logic       last_word;
  cmd_hdr_t   hdr;

  assign cnt_m1    = imem_cfg.data_cnt - 8'd1;
  assign last_word = (cnt == cnt_m1[7:2]);
  assign hdr = '{data_cnt: imem_cfg.data_cnt, dummy_cnt: imem_cfg.dummy_cnt,
                 addr_cnt: imem_cfg.addr_cnt, seq: imem_cfg.seq,
                 mode: imem_cfg.mode, cmd: imem_cfg.cmd};

  always_ff @(posedge mclk) begin
    if (!rst_n || imem_cfg.fsm_reset) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      state <= next_state;
      cnt   <= next_cnt;
    end
  end

  // Readback copy of IMEM_WDATA
  always_ff @(posedge mclk) begin
    if (wr_req && wrdy) wdata_last <= wr_data;
  end

  // ------------------------------------------------------------------
  // Next state and FIFO strobes
  // ------------------------------------------------------------------
  always_comb begin
    next_state     = state;
    next_cnt       = cnt;
    wrdy           = 1'b0;
    rrdy           = 1'b0;
    rdata          = '0;
    cmd_fifo_wr    = 1'b0;
    cmd_fifo_wdata = '0;
    res_fifo_rd    = 1'b0;

    case (state)
      S_IDLE: begin
        next_cnt = '0;
        if ((wr_req || rd_req) && cmd_fifo_empty && !imem_cfg.fsm_reset) begin
          cmd_fifo_wr    = 1'b1;
          cmd_fifo_wdata = '{soc: 1'b1, eoc: 1'b0, payload: hdr};
          case (imem_cfg.seq)
            P_FSM_C: begin
              cmd_fifo_wdata.eoc = 1'b1;   // Header is the whole command
              wrdy       = 1'b1;
              next_state = S_ACK;
            end
            P_FSM_CW, P_FSM_CDW: next_state = S_WRITE;
            P_FSM_CA, P_FSM_CAR, P_FSM_CADR, P_FSM_CAMR, P_FSM_CAMDR,
            P_FSM_CAW, P_FSM_CADW, P_FSM_CAMW: next_state = S_ADDR;
            P_FSM_CDR, P_FSM_CR: begin
              cmd_fifo_wdata.eoc = 1'b1;
              next_state = S_READ;
            end
            default: cmd_fifo_wr = 1'b0;   // Unused code, nothing sent
          endcase
        end
      end
      S_ADDR: begin
        if (!cmd_fifo_full) begin
          cmd_fifo_wr    = 1'b1;
          cmd_fifo_wdata = '{soc: 1'b0, eoc: 1'b1, payload: {2'b00, imem_addr}};
          case (imem_cfg.seq)
            P_FSM_CA: begin
              wrdy       = 1'b1;
              next_state = S_ACK;
            end
            P_FSM_CAW, P_FSM_CADW, P_FSM_CAMW: begin
              cmd_fifo_wdata.eoc = 1'b0;   // Data words follow
              next_state = S_WRITE;
            end
            default: next_state = S_READ;
          endcase
        end
      end
      S_WRITE: begin
        if (!cmd_fifo_full && wr_req) begin
          wrdy           = 1'b1;
          cmd_fifo_wr    = 1'b1;
          cmd_fifo_wdata = '{soc: 1'b0, eoc: last_word, payload: {2'b00, wr_data}};
          if (last_word) begin
            next_state = S_ACK;
          end else begin
            next_state = S_WR_BUSY;
            next_cnt   = cnt + 6'd1;
          end
        end
      end
      S_WR_BUSY: if (!wr_req) next_state = S_WRITE;   // Wait for bus to drop stb
      S_READ: begin
        if (!res_fifo_empty && rd_req) begin
          rrdy        = 1'b1;
          rdata       = res_fifo_rdata;
          res_fifo_rd = 1'b1;
          if (last_word) begin
            next_state = S_ACK;
          end else begin
            next_state = S_RD_BUSY;
            next_cnt   = cnt + 6'd1;
          end
        end
      end
      S_RD_BUSY: if (!rd_req) next_state = S_READ;
      S_ACK:     next_state = S_IDLE;   // Gap before next launch
      default:   next_state = S_IDLE;
    endcase
  end

endmodule

/* design/qspim_regs.sv */
// Register and indirect access front end of the quad SPI controller
// Wishbone classic slave, one outstanding cycle, registered ack
// Command and response FIFOs live outside this block

`timescale 1ns/1ps

module qspim_regs import qspim_pkg::*; (
  input  logic             mclk,
  input  logic             rst_n,
  input  wb_req_t          wb_req,
  output logic             wb_ack,
  output logic [WB_DW-1:0] wb_rdata,
  output glbl_cfg_t        glbl_cfg,
  output spi_mode_cfg_t    dmem_cfg,
  output cs_map_t          dmem_cs_map,
  output logic [3:0]       imem_cs,
  input  logic             cmd_fifo_full,
  input  logic             cmd_fifo_empty,
  output logic             cmd_fifo_wr,
  output cmd_word_t        cmd_fifo_wdata,
  input  logic             res_fifo_empty,
  input  logic [WB_DW-1:0] res_fifo_rdata,
  output logic             res_fifo_rd
);

  logic             reg_we;
  logic [WB_DW-1:0] reg_rdata;
  logic             imem_wr_req;     // IMEM_WDATA write pending
  logic             imem_rd_req;     // IMEM_RDATA read pending
  logic             wrdy;
  logic             rrdy;
  logic [WB_DW-1:0] imem_rdata;
  logic [WB_DW-1:0] imem_wdata_last;
  spi_mode_cfg_t    imem_cfg;
  logic [31:0]      imem_addr;

  // Bus decode and ack
  qspim_wb_slave i_wb_slave (
    .mclk, .rst_n, .wb_req, .wb_ack, .wb_rdata,
    .reg_we, .reg_rdata,
    .imem_wr_req, .imem_rd_req, .wrdy, .rrdy, .imem_rdata
  );

  // Configuration registers
  qspim_cfg_regs i_cfg_regs (
    .mclk, .rst_n, .wb_req, .reg_we, .reg_rdata,
    .glbl_cfg, .dmem_cfg, .dmem_cs_map, .imem_cs,
    .imem_cfg, .imem_addr, .imem_wdata_last
  );

  // Indirect engine, data comes straight off the bus
  qspim_imem_ctrl i_imem_ctrl (
    .mclk, .rst_n, .imem_cfg, .imem_addr,
    .wr_req     (imem_wr_req),
    .wr_data    (wb_req.dat),
    .rd_req     (imem_rd_req),
    .wrdy, .rrdy,
    .rdata      (imem_rdata),
    .wdata_last (imem_wdata_last),
    .cmd_fifo_full, .cmd_fifo_empty, .cmd_fifo_wr, .cmd_fifo_wdata,
    .res_fifo_empty, .res_fifo_rdata, .res_fifo_rd
  );

endmodule

/* tests/tb_qspim_regs.sv */
// Testbench for the register front end with one Wishbone cycle per table entry
// Command FIFO model logs every push and only goes full when the table asks
// Response words are preloaded from the table before reset is released

`timescale 1ns/1ps

module tb_qspim_regs import qspim_pkg::*; ();

  localparam int ACK_WAIT         = 40;   // Cycles before a missing ack is declared
  localparam int CYCLES_PER_ENTRY = 64;

  typedef struct packed {
    logic             we;
    logic [3:0]       adr;
    logic [3:0]       sel;
    logic [31:0]      wdata;
    logic [31:0]      rdata;   // Expected read data
    logic             ack;     // Ack expected at all
    logic [3:0]       hold;    // Cycles of cmd_fifo_full
    logic [1:0]       ncmd;
    logic [2:0][35:0] cmd;     // Expected command words in order
  } entry_t;

  logic             mclk;
  logic             rst_n;
  wb_req_t          wb_req;
  logic             wb_ack;
  logic [WB_DW-1:0] wb_rdata;
  glbl_cfg_t        glbl_cfg;
  spi_mode_cfg_t    dmem_cfg;
  cs_map_t          dmem_cs_map;
  logic [3:0]       imem_cs;
  logic             cmd_fifo_full;
  logic             cmd_fifo_empty;
  logic             cmd_fifo_wr;
  cmd_word_t        cmd_fifo_wdata;
  logic             res_fifo_empty;
  logic [31:0]      res_fifo_rdata;
  logic             res_fifo_rd;

  logic [35:0] cmd_q[$];     // Every pushed command word
  logic [31:0] res_q[$];     // Response FIFO contents
  entry_t      tbl[$];
  int          mismatch_cnt;
  int          timeout_cnt;
  int          cycles;
  int          cycle_limit;
  int unsigned seed;

  qspim_regs i_qspim_regs (
    .mclk, .rst_n, .wb_req, .wb_ack, .wb_rdata,
    .glbl_cfg, .dmem_cfg, .dmem_cs_map, .imem_cs,
    .cmd_fifo_full, .cmd_fifo_empty, .cmd_fifo_wr, .cmd_fifo_wdata,
    .res_fifo_empty, .res_fifo_rdata, .res_fifo_rd
  );

  initial begin
    mclk = 1'b0;
    forever #5 mclk = ~mclk;
  end

  // ------------------------------------------------------------------
  // FIFO models and watchdog
  // ------------------------------------------------------------------
  always @(posedge mclk) begin
    if (rst_n && cmd_fifo_wr) cmd_q.push_back(cmd_fifo_wdata);
  end

  always @(posedge mclk) begin
    if (rst_n && res_fifo_rd) begin
      if (res_q.size() == 0) report_mismatch("response FIFO popped while empty");
      else void'(res_q.pop_front());
    end
    res_fifo_empty <= (res_q.size() == 0);
    res_fifo_rdata <= (res_q.size() != 0) ? res_q[0] : 32'h0;   // Show-ahead head
  end

  always @(posedge mclk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    mismatch_cnt++;
  endtask

  // Header fields in order soc, eoc, data count, dummy, address count, sequence, mode, command
  function automatic logic [35:0] hdr_word(logic soc, logic eoc, logic [7:0] dcnt,
                                           logic [3:0] dummy, logic [1:0] acnt,
                                           logic [3:0] seq, logic [7:0] mode,
                                           logic [7:0] cmd);
    return {soc, eoc, dcnt, dummy, acnt, seq, mode, cmd};
  endfunction

  function automatic logic [35:0] data_word(logic eoc, logic [31:0] d);
    return {1'b0, eoc, 2'b00, d};
  endfunction

  task automatic push_entry(input logic we, input logic [3:0] adr, input logic [3:0] sel,
                            input logic [31:0] wdata, input logic [31:0] rdata,
                            input logic ack, input logic stall, input logic [1:0] ncmd,
                            input logic [35:0] c0, input logic [35:0] c1,
                            input logic [35:0] c2);
    entry_t e;
    e       = '0;
    e.we    = we;
    e.adr   = adr;
    e.sel   = sel;
    e.wdata = wdata;
    e.rdata = rdata;
    e.ack   = ack;
    e.hold  = stall ? 4'(2 + $urandom % 8) : 4'd0;   // 2 to 9 cycles
    e.ncmd  = ncmd;
    e.cmd   = {c2, c1, c0};
    tbl.push_back(e);
  endtask

  task automatic add_write(input logic [3:0] adr, input logic [3:0] sel,
                           input logic [31:0] d);
    push_entry(1'b1, adr, sel, d, 32'h0, 1'b1, 1'b0, 2'd0, '0, '0, '0);
  endtask

  task automatic add_read(input logic [3:0] adr, input logic [31:0] exp);
    push_entry(1'b0, adr, 4'hF, 32'h0, exp, 1'b1, 1'b0, 2'd0, '0, '0, '0);
  endtask

  // Outputs must agree with the fields of the expected register word
  task automatic check_outputs(input logic [3:0] adr, input logic [31:0] d);
    case (adr)
      GLBL_CTRL:
        if (glbl_cfg !== {d[1:0], d[3:2], d[15:8]})
          report_mismatch($sformatf("glbl_cfg %h vs expected %h", glbl_cfg, d));
      DMEM_CTRL1:
        if ({dmem_cfg.imode, dmem_cfg.fmode, dmem_cfg.switch, dmem_cfg.dummy_cnt,
             dmem_cfg.fsm_reset} !== {d[5:4], d[7:6], d[9:8], d[13:10], d[15]})
          report_mismatch($sformatf("dmem_cfg ctrl1 fields vs expected %h", d));
      DMEM_CTRL2:
        if ({dmem_cfg.cmd, dmem_cfg.mode, dmem_cfg.seq, dmem_cfg.addr_cnt,
             dmem_cfg.data_cnt} !== {d[7:0], d[15:8], d[19:16], d[21:20], d[31:24]})
          report_mismatch($sformatf("dmem_cfg ctrl2 fields vs expected %h", d));
      DMEM_CS_AMAP:
        if (dmem_cs_map.addr !== d)
          report_mismatch($sformatf("cs map addr %h vs %h", dmem_cs_map.addr, d));
      DMEM_CS_AMASK:
        if (dmem_cs_map.amask !== d)
          report_mismatch($sformatf("cs map mask %h vs %h", dmem_cs_map.amask, d));
      IMEM_CTRL1:
        if (imem_cs !== d[3:0])
          report_mismatch($sformatf("imem_cs %h vs %h", imem_cs, d[3:0]));
      default: ;
    endcase
  endtask

  // One Wishbone classic cycle with optional cmd_fifo_full hold
  task automatic run_entry(input entry_t e, input int idx);
    int base;
    int n;
    int wait_cnt;
    int hold_left;
    bit acked;
    base      = cmd_q.size();
    hold_left = e.hold;
    acked     = 1'b0;
    wait_cnt  = 0;
    @(posedge mclk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: e.we, sel: e.sel, adr: e.adr, dat: e.wdata};
    if (hold_left > 0) begin
      cmd_fifo_full  <= 1'b1;
      cmd_fifo_empty <= 1'b0;
    end
    while (!acked && wait_cnt < ACK_WAIT) begin
      @(posedge mclk);
      wait_cnt++;
      if (cmd_fifo_full && (wb_ack || cmd_fifo_wr))
        report_mismatch($sformatf("entry %0d ack or push while FIFO full", idx));
      if (wb_ack) begin
        acked = 1'b1;
      end else if (hold_left > 0) begin
        hold_left--;
        if (hold_left == 0) begin
          cmd_fifo_full  <= 1'b0;   // Release back-pressure
          cmd_fifo_empty <= 1'b1;
        end
      end
    end
    wb_req         <= '0;
    cmd_fifo_full  <= 1'b0;
    cmd_fifo_empty <= 1'b1;
    if (!acked && e.ack) begin
      $display("timeout: no acknowledge for entry %0d at address %0h", idx, e.adr);
      timeout_cnt++;
    end
    if (acked && !e.ack) report_mismatch($sformatf("entry %0d acked while held", idx));
    @(posedge mclk);
    if (acked && wb_ack) report_mismatch($sformatf("entry %0d ack wider than one cycle", idx));
    if (acked && !e.we) begin
      if (wb_rdata !== e.rdata)
        report_mismatch($sformatf("entry %0d adr %0h read %h, expected %h",
                                  idx, e.adr, wb_rdata, e.rdata));
      check_outputs(e.adr, e.rdata);
    end
    n = cmd_q.size() - base;
    if (n != e.ncmd) begin
      report_mismatch($sformatf("entry %0d pushed %0d words, expected %0d", idx, n, e.ncmd));
    end else begin
      for (int k = 0; k < n; k++) begin
        if (cmd_q[base+k] !== e.cmd[k])
          report_mismatch($sformatf("entry %0d word %0d is %h, expected %h",
                                    idx, k, cmd_q[base+k], e.cmd[k]));
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Stimulus table and run
  // ------------------------------------------------------------------
  initial begin
    mismatch_cnt   = 0;
    timeout_cnt    = 0;
    cycles         = 0;
    rst_n          = 1'b0;
    wb_req         = '0;
    cmd_fifo_full  = 1'b0;
    cmd_fifo_empty = 1'b1;
    res_fifo_empty = 1'b1;
    res_fifo_rdata = '0;
    seed           = 32'h8cff;
    void'($urandom(seed));

    // Reset defaults
    add_read(GLBL_CTRL,     32'h0000_0205);
    add_read(DMEM_CTRL1,    32'h0000_05A0);   // Quad, switch at addr, 1 dummy
    add_read(DMEM_CTRL2,    32'h2026_00EB);   // QIOR, CAMDR, 32 bytes
    add_read(DMEM_CS_AMAP,  32'h3020_1000);
    add_read(DMEM_CS_AMASK, 32'hF0F0_F0F0);
    add_read(IMEM_CTRL1,    32'h0000_02A1);
    add_read(IMEM_CTRL2,    32'h0024_006B);
    // Byte lanes
    add_write(GLBL_CTRL, 4'b0010, 32'hA5A5_3A0E);
    add_read(GLBL_CTRL, 32'h0000_3A05);
    add_write(GLBL_CTRL, 4'b0001, 32'h0000_FF0E);
    add_read(GLBL_CTRL, 32'h0000_3A0E);
    add_write(DMEM_CTRL2, 4'b1001, 32'h1122_3344);
    add_read(DMEM_CTRL2, 32'h1126_0044);
    add_write(DMEM_CS_AMAP, 4'b0110, 32'hAABB_CCDD);
    add_read(DMEM_CS_AMAP, 32'h30BB_CC00);
    add_write(DMEM_CS_AMASK, 4'b1000, 32'h1234_5678);
    add_read(DMEM_CS_AMASK, 32'h12F0_F0F0);
    // Indirect write as CAW with 8 bytes
    add_write(IMEM_CTRL2, 4'hF, 32'h0827_0032);
    add_write(IMEM_ADDR, 4'hF, 32'h0012_3400);
    push_entry(1'b1, IMEM_WDATA, 4'hF, 32'hDEAD_BEEF, 32'h0, 1'b1, 1'b0, 2'd3,
               hdr_word(1'b1, 1'b0, 8'd8, 4'd0, 2'd2, P_FSM_CAW, 8'h00, 8'h32),
               data_word(1'b0, 32'h0012_3400), data_word(1'b0, 32'hDEAD_BEEF));
    push_entry(1'b1, IMEM_WDATA, 4'hF, 32'hCAFE_F00D, 32'h0, 1'b1, 1'b0, 2'd1,
               data_word(1'b1, 32'hCAFE_F00D), '0, '0);
    add_read(IMEM_WDATA, 32'hCAFE_F00D);
    // Indirect read as CAR with 8 bytes
    add_write(IMEM_CTRL2, 4'hF, 32'h0823_006B);
    add_write(IMEM_ADDR, 4'hF, 32'h0040_0000);
    push_entry(1'b0, IMEM_RDATA, 4'hF, 32'h0, 32'h1357_9BDF, 1'b1, 1'b0, 2'd2,
               hdr_word(1'b1, 1'b0, 8'd8, 4'd0, 2'd2, P_FSM_CAR, 8'h00, 8'h6B),
               data_word(1'b1, 32'h0040_0000), '0);
    push_entry(1'b0, IMEM_RDATA, 4'hF, 32'h0, 32'h2468_ACE0, 1'b1, 1'b0, 2'd0,
               '0, '0, '0);
    // Back-pressure on launch and on the second data word
    add_write(IMEM_CTRL2, 4'hF, 32'h0827_0032);
    add_write(IMEM_ADDR, 4'hF, 32'h0000_0100);
    push_entry(1'b1, IMEM_WDATA, 4'hF, 32'h1111_1111, 32'h0, 1'b1, 1'b1, 2'd3,
               hdr_word(1'b1, 1'b0, 8'd8, 4'd0, 2'd2, P_FSM_CAW, 8'h00, 8'h32),
               data_word(1'b0, 32'h0000_0100), data_word(1'b0, 32'h1111_1111));
    push_entry(1'b1, IMEM_WDATA, 4'hF, 32'h2222_2222, 32'h0, 1'b1, 1'b1, 2'd1,
               data_word(1'b1, 32'h2222_2222), '0, '0);
    // Engine held by fsm_reset and then a command-only transfer
    add_write(IMEM_CTRL2, 4'hF, 32'h0000_0006);
    add_write(IMEM_CTRL1, 4'b0010, 32'h0000_8000);
    add_read(IMEM_CTRL1, 32'h0000_80A1);
    push_entry(1'b1, IMEM_WDATA, 4'hF, 32'h0BAD_0BAD, 32'h0, 1'b0, 1'b0, 2'd0,
               '0, '0, '0);
    add_write(IMEM_CTRL1, 4'b0010, 32'h0000_0000);
    add_read(IMEM_CTRL1, 32'h0000_00A1);
    push_entry(1'b1, IMEM_WDATA, 4'hF, 32'h0000_0000, 32'h0, 1'b1, 1'b0, 2'd1,
               hdr_word(1'b1, 1'b1, 8'd0, 4'd0, 2'd0, P_FSM_C, 8'h00, 8'h06), '0, '0);

    cycle_limit = tbl.size() * CYCLES_PER_ENTRY;
    foreach (tbl[i]) begin
      if (!tbl[i].we && tbl[i].adr == IMEM_RDATA) res_q.push_back(tbl[i].rdata);
    end

    repeat (3) @(posedge mclk);
    rst_n <= 1'b1;
    @(posedge mclk);
    if (wb_ack !== 1'b0 || cmd_fifo_wr !== 1'b0 || res_fifo_rd !== 1'b0)
      report_mismatch("ack or FIFO strobe not low after reset");

    foreach (tbl[i]) begin
      run_entry(tbl[i], i);
    end
    if (res_q.size() != 0)
      report_mismatch($sformatf("%0d response words left unread", res_q.size()));

    $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* src.f */
common/qspim_pkg.sv
design/qspim_wb_slave.sv
design/qspim_cfg_regs.sv
design/qspim_imem_ctrl.sv
design/qspim_regs.sv
tests/tb_qspim_regs.sv

/* Bender.yml */
package:
  name: qspim_regs

sources:
  - common/qspim_pkg.sv
  - design/qspim_wb_slave.sv
  - design/qspim_cfg_regs.sv
  - design/qspim_imem_ctrl.sv
  - design/qspim_regs.sv
  - target: test
    files:
      - tests/tb_qspim_regs.sv
